// ==== source/tpuDispatch_params.svh ====
`ifndef TPU_DISPATCH_PARAMS_SVH
`define TPU_DISPATCH_PARAMS_SVH

// Field widths
`define INSTR_W      32
`define OPCODE_W     6
`define OPCLASS_W    2
`define REG_IDX_W    5
`define IMM_W        10
`define COUNT_W      8

// Queue depth, must be a power of two
`define QUEUE_DEPTH  4

// Low bit of each field in the instruction word, bit 0 reserved
`define OPCODE_LSB   26
`define DST_LSB      21
`define SRC1_LSB     16
`define SRC2_LSB     11
`define IMM_LSB      1

// Opcode sub-fields
`define VECTOR_BIT   3
`define SUBOP_W      3
`define SUBOP_MAX    3'd3

`endif

// ==== source/tpuDispatchPkg.sv ====
package tpuDispatchPkg;

	`include "tpuDispatch_params.svh"

	// ====================
	// Vector types
	// ====================

	// Raw host word
	typedef logic [`INSTR_W-1:0]    instrWord_t;

	// Top two bits hold the class, bit 3 asks for vector
	typedef logic [`OPCODE_W-1:0]   opCode_t;

	// 0 ALU, 1 MAC, 2 load/store, 3 control
	typedef logic [`OPCLASS_W-1:0]  opClass_t;

	typedef logic [`REG_IDX_W-1:0]  regIdx_t;
	typedef logic [`IMM_W-1:0]      imm_t;

	// Illegal word counter, saturating
	typedef logic [`COUNT_W-1:0]    count_t;

	// Queue read and write pointers
	typedef logic [$clog2(`QUEUE_DEPTH)-1:0] queuePtr_t;

	// Control class, always scalar
	localparam opClass_t CLASS_CTRL = 2'd3;

	// ====================
	// State machines
	// ====================

	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_PUSH,
		DEC_ACK
	} decState_t;

	typedef enum logic [1:0] {
		DISP_IDLE,
		DISP_REQ,
		DISP_RELEASE
	} dispState_t;

endpackage

// ==== source/commandDecoder.sv ====
`timescale 1ns/100ps

`include "tpuDispatch_params.svh"

module commandDecoder
	import tpuDispatchPkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	input  logic       instrReq,
	input  instrWord_t instrWord,
	output logic       instrAck,
	input  logic       full,
	output logic       push,
	output opCode_t    opCode,
	output regIdx_t    dst,
	output regIdx_t    src1,
	output regIdx_t    src2,
	output imm_t       imm,
	output logic       toVector,
	output count_t     illegalCount
);

	decState_t state;

	opCode_t   wordOpCode;
	opClass_t  wordClass;
	logic      wordIsCtrl;
	logic      wordIllegal;
	logic      wordToVector;
	logic      latchWord;

	// ====================
	// Field split and rules
	// ====================

	assign wordOpCode   = instrWord[`OPCODE_LSB +: `OPCODE_W];
	assign wordClass    = wordOpCode[`OPCODE_W-1 -: `OPCLASS_W];
	assign wordIsCtrl   = (wordClass == CLASS_CTRL);

	// Control sub-ops above 3 are not defined
	assign wordIllegal  = wordIsCtrl && (wordOpCode[`SUBOP_W-1:0] > `SUBOP_MAX);

	// Control never goes to the vector unit
	assign wordToVector = wordOpCode[`VECTOR_BIT] && !wordIsCtrl;

	// Take a word only when the queue has room
	assign latchWord    = (state == DEC_IDLE) && instrReq && !full;

	// ====================
	// Host handshake FSM
	// ====================

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state        <= DEC_IDLE;
			push         <= 1'b0;
			instrAck     <= 1'b0;
			illegalCount <= '0;
		end else begin
			case (state)
				DEC_IDLE: begin
					if (latchWord) begin
						if (wordIllegal) begin
							// Dropped word, ack it and count
							state    <= DEC_ACK;
							instrAck <= 1'b1;
							if (illegalCount != '1) begin
								illegalCount <= illegalCount + 1'b1;
							end
						end else begin
							state <= DEC_PUSH;
							push  <= 1'b1;
						end
					end
				end
				DEC_PUSH: begin
					push     <= 1'b0;
					instrAck <= 1'b1;
					state    <= DEC_ACK;
				end
				DEC_ACK: begin
					// Wait for the host to release req
					if (!instrReq) begin
						instrAck <= 1'b0;
						state    <= DEC_IDLE;
					end
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

	// Decoded fields, held for the push cycle
	always_ff @(posedge clk) begin
		if (latchWord) begin
			opCode   <= wordOpCode;
			dst      <= instrWord[`DST_LSB +: `REG_IDX_W];
			src1     <= instrWord[`SRC1_LSB +: `REG_IDX_W];
			src2     <= instrWord[`SRC2_LSB +: `REG_IDX_W];
			imm      <= instrWord[`IMM_LSB +: `IMM_W];
			toVector <= wordToVector;
		end
	end

	pushNotFull: assert property (@(posedge clk) disable iff (!rstN) push |-> !full);

endmodule

// ==== source/commandQueue.sv ====
`timescale 1ns/100ps

`include "tpuDispatch_params.svh"

module commandQueue
	import tpuDispatchPkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    push,
	input  logic    pop,
	input  opCode_t opCode,
	input  regIdx_t dst,
	input  regIdx_t src1,
	input  regIdx_t src2,
	input  imm_t    imm,
	input  logic    toVector,
	output opCode_t headOpCode,
	output regIdx_t headDst,
	output regIdx_t headSrc1,
	output regIdx_t headSrc2,
	output imm_t    headImm,
	output logic    headToVector,
	output logic    full,
	output logic    empty
);

	localparam int PTR_W   = $bits(queuePtr_t);
	localparam int ENTRY_W = `OPCODE_W + 3 * `REG_IDX_W + `IMM_W + 1;

	logic [ENTRY_W-1:0] entries [`QUEUE_DEPTH];
	logic [ENTRY_W-1:0] headEntry;

	queuePtr_t        wrPtr;
	queuePtr_t        rdPtr;
	logic [PTR_W:0]   occupancy;

	// ====================
	// Storage
	// ====================

	// One packed entry per command
	always_ff @(posedge clk) begin
		if (push) begin
			entries[wrPtr] <= {opCode, dst, src1, src2, imm, toVector};
		end
	end

	assign headEntry = entries[rdPtr];
	assign {headOpCode, headDst, headSrc1, headSrc2, headImm, headToVector} = headEntry;

	// ====================
	// Pointers and count
	// ====================

	// Depth is a power of two so the pointers wrap on their own
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			occupancy <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	assign full  = (occupancy == (PTR_W + 1)'(`QUEUE_DEPTH));
	assign empty = (occupancy == '0);

	noPopEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty);
	noPushFull: assert property (@(posedge clk) disable iff (!rstN) push |-> !full);

endmodule

// ==== source/unitDispatch.sv ====
`timescale 1ns/100ps

module unitDispatch
	import tpuDispatchPkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    empty,
	input  opCode_t headOpCode,
	input  regIdx_t headDst,
	input  regIdx_t headSrc1,
	input  regIdx_t headSrc2,
	input  imm_t    headImm,
	input  logic    headToVector,
	output logic    pop,
	output logic    sReq,
	input  logic    sAck,
	output opCode_t sOpCode,
	output regIdx_t sDst,
	output regIdx_t sSrc1,
	output regIdx_t sSrc2,
	output imm_t    sImm,
	output logic    vReq,
	input  logic    vAck,
	output opCode_t vOpCode,
	output regIdx_t vDst,
	output regIdx_t vSrc1,
	output regIdx_t vSrc2,
	output imm_t    vImm
);

	dispState_t state;

	logic selVector;
	logic ackSel;
	logic loadCmd;
	logic loadScalar;
	logic loadVector;

	// Ack of whichever port holds the command
	assign ackSel     = selVector ? vAck : sAck;
	assign loadCmd    = (state == DISP_IDLE) && !empty;
	assign loadScalar = loadCmd && !headToVector;
	assign loadVector = loadCmd && headToVector;

	// Pop once the unit has dropped its ack
	assign pop     = (state == DISP_RELEASE) && !ackSel;

	// ====================
	// Port handshake FSM
	// ====================

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state     <= DISP_IDLE;
			selVector <= 1'b0;
			sReq      <= 1'b0;
			vReq      <= 1'b0;
		end else begin
			case (state)
				DISP_IDLE: begin
					if (loadCmd) begin
						selVector <= headToVector;
						sReq      <= !headToVector;
						vReq      <= headToVector;
						state     <= DISP_REQ;
					end
				end
				DISP_REQ: begin
					if (ackSel) begin
						sReq  <= 1'b0;
						vReq  <= 1'b0;
						state <= DISP_RELEASE;
					end
				end
				DISP_RELEASE: begin
					if (!ackSel) begin
						state <= DISP_IDLE;
					end
				end
				default: state <= DISP_IDLE;
			endcase
		end
	end

	// ====================
	// Port steering
	// ====================

	// A pop clears both ports and a load zeroes the one not chosen
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			sOpCode <= '0;
			sDst    <= '0;
			sSrc1   <= '0;
			sSrc2   <= '0;
			sImm    <= '0;
			vOpCode <= '0;
			vDst    <= '0;
			vSrc1   <= '0;
			vSrc2   <= '0;
			vImm    <= '0;
		end else if (pop || loadCmd) begin
			sOpCode <= loadScalar ? headOpCode : '0;
			sDst    <= loadScalar ? headDst : '0;
			sSrc1   <= loadScalar ? headSrc1 : '0;
			sSrc2   <= loadScalar ? headSrc2 : '0;
			sImm    <= loadScalar ? headImm : '0;
			vOpCode <= loadVector ? headOpCode : '0;
			vDst    <= loadVector ? headDst : '0;
			vSrc1   <= loadVector ? headSrc1 : '0;
			vSrc2   <= loadVector ? headSrc2 : '0;
			vImm    <= loadVector ? headImm : '0;
		end
	end

	oneReq: assert property (@(posedge clk) disable iff (!rstN) !(sReq && vReq));

endmodule

// ==== source/tpuDispatch.sv ====
`timescale 1ns/100ps

module tpuDispatch
	import tpuDispatchPkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	input  logic       instrReq,
	input  instrWord_t instrWord,
	output logic       instrAck,
	output logic       sReq,
	input  logic       sAck,
	output opCode_t    sOpCode,
	output regIdx_t    sDst,
	output regIdx_t    sSrc1,
	output regIdx_t    sSrc2,
	output imm_t       sImm,
	output logic       vReq,
	input  logic       vAck,
	output opCode_t    vOpCode,
	output regIdx_t    vDst,
	output regIdx_t    vSrc1,
	output regIdx_t    vSrc2,
	output imm_t       vImm,
	output count_t     illegalCount
);

	// Decoder to queue
	logic    push;
	logic    full;
	opCode_t opCode;
	regIdx_t dst;
	regIdx_t src1;
	regIdx_t src2;
	imm_t    imm;
	logic    toVector;

	// Queue to dispatcher
	logic    pop;
	logic    empty;
	opCode_t headOpCode;
	regIdx_t headDst;
	regIdx_t headSrc1;
	regIdx_t headSrc2;
	imm_t    headImm;
	logic    headToVector;

	commandDecoder u_decoder (
		.clk, .rstN,
		.instrReq, .instrWord, .instrAck,
		.full, .push,
		.opCode, .dst, .src1, .src2, .imm, .toVector,
		.illegalCount
	);

	commandQueue u_queue (
		.clk, .rstN,
		.push, .pop,
		.opCode, .dst, .src1, .src2, .imm, .toVector,
		.headOpCode, .headDst, .headSrc1, .headSrc2, .headImm, .headToVector,
		.full, .empty
	);

	unitDispatch u_dispatch (
		.clk, .rstN,
		.empty,
		.headOpCode, .headDst, .headSrc1, .headSrc2, .headImm, .headToVector,
		.pop,
		.sReq, .sAck, .sOpCode, .sDst, .sSrc1, .sSrc2, .sImm,
		.vReq, .vAck, .vOpCode, .vDst, .vSrc1, .vSrc2, .vImm
	);

endmodule

// ==== verif/tbClock.sv ====
`timescale 1ns/100ps

module tbClock (
	output logic clk,
	output logic rstN
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset held low for three rising edges
	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

// ==== verif/dispatchChecker.sv ====
`timescale 1ns/100ps

module dispatchChecker
	import tpuDispatchPkg::*;
#(
	parameter int NUM_WORDS = 24
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic        instrAck,
	input  logic        sReq,
	input  logic        sAck,
	input  logic [30:0] sFields,
	input  logic        vReq,
	input  logic        vAck,
	input  logic [30:0] vFields,
	input  count_t      illegalCount,
	input  logic        finalCheck,
	output logic        allDispatched,
	output logic        reportDone,
	output int          failCount
);

	logic [39:0] stimulus [NUM_WORDS];
	logic [30:0] heldFields    = '0;
	logic        prevSReq      = 1'b0;
	logic        prevVReq      = 1'b0;
	logic        prevAck       = 1'b0;
	logic        resetChecked  = 1'b0;
	logic        finalDone     = 1'b0;
	int          nextIdx       = 0;
	int          legalCount    = 0;
	int          illegalLines  = 0;
	int          dispatchCount = 0;
	int          ackCount      = 0;
	int          errors        = 0;
	int          stimErrors    = 0;

	assign failCount = errors + stimErrors;

	// Expected unit by the decode rules (0 scalar, 1 vector, 2 illegal)
	function automatic logic [3:0] ruleUnit(input logic [31:0] word);
		logic [1:0] opClass;
		opClass = word[31:30];
		if (opClass == 2'd3 && word[28:26] > 3'd3) return 4'd2;
		return (word[29] && opClass != 2'd3) ? 4'd1 : 4'd0;
	endfunction

	// Result word for a per-test line
	function automatic string verdict(input int errorsBefore);
		if (errors == errorsBefore)
			return "ok";
		return "mismatch";
	endfunction

	initial begin
		$readmemh("verif/dispatch_stimulus.txt", stimulus);
		for (int i = 0; i < NUM_WORDS; i++) begin
			if (stimulus[i][3:0] != ruleUnit(stimulus[i][35:4])) begin
				$display("stimulus entry %0d disagrees with the decode rules", i);
				stimErrors++;
			end
			if (stimulus[i][3:0] == 4'd2)
				illegalLines++;
			else
				legalCount++;
		end
	end

	task automatic valueError(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("error at %0t: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic plainError(input string what);
		$display("at %0t: %s", $time, what);
		errors++;
	endtask

	// Port fields in word order from opcode down to imm
	task automatic comparePort(input string port, input logic [30:0] expected,
		input logic [30:0] actual);
		if (actual[30:25] != expected[30:25])
			valueError({port, "OpCode"}, 32'(expected[30:25]), 32'(actual[30:25]));
		if (actual[24:20] != expected[24:20])
			valueError({port, "Dst"}, 32'(expected[24:20]), 32'(actual[24:20]));
		if (actual[19:15] != expected[19:15])
			valueError({port, "Src1"}, 32'(expected[19:15]), 32'(actual[19:15]));
		if (actual[14:10] != expected[14:10])
			valueError({port, "Src2"}, 32'(expected[14:10]), 32'(actual[14:10]));
		if (actual[9:0] != expected[9:0])
			valueError({port, "Imm"}, 32'(expected[9:0]), 32'(actual[9:0]));
	endtask

	task automatic skipIllegal();
		while (nextIdx < NUM_WORDS && stimulus[nextIdx][3:0] == 4'd2) begin
			$display("word %0d: illegal, dropped", nextIdx);
			nextIdx++;
		end
	endtask

	task automatic takeDispatch(input logic toVector);
		int errorsBefore;
		skipIllegal();
		if (nextIdx >= NUM_WORDS) begin
			plainError("dispatch seen after the last legal word");
			return;
		end
		errorsBefore = errors;
		if (stimulus[nextIdx][3:0] != {3'b000, toVector})
			plainError($sformatf("word %0d sent to the wrong unit", nextIdx));
		// Fields are the word without its reserved bit 0
		comparePort(toVector ? "v" : "s", stimulus[nextIdx][35:5],
			toVector ? vFields : sFields);
		comparePort(toVector ? "s" : "v", '0, toVector ? sFields : vFields);
		heldFields = toVector ? vFields : sFields;
		$display("word %0d: %s dispatch %s", nextIdx, toVector ? "vector" : "scalar",
			verdict(errorsBefore));
		dispatchCount++;
		nextIdx++;
	endtask

	// ====================
	// Port watch
	// ====================

	always @(posedge clk) begin : watch
		int errorsBefore;
		if (!rstN) begin
			prevSReq = 1'b0;
			prevVReq = 1'b0;
			prevAck  = 1'b0;
			allDispatched <= 1'b0;
			reportDone    <= 1'b0;
		end else begin
			if (!resetChecked) begin
				errorsBefore = errors;
				if (instrAck !== 1'b0)
					valueError("instrAck", 32'd0, 32'(instrAck));
				if (sReq !== 1'b0)
					valueError("sReq", 32'd0, 32'(sReq));
				if (vReq !== 1'b0)
					valueError("vReq", 32'd0, 32'(vReq));
				if (illegalCount !== '0)
					valueError("illegalCount", 32'd0, 32'(illegalCount));
				comparePort("s", '0, sFields);
				comparePort("v", '0, vFields);
				$display("reset values: %s", verdict(errorsBefore));
				resetChecked = 1'b1;
			end
			if (sReq && vReq) plainError("sReq and vReq high together");
			if (instrAck && !prevAck) ackCount++;
			if (sReq && !prevSReq) takeDispatch(1'b0);
			if (vReq && !prevVReq) takeDispatch(1'b1);
			if (prevSReq && !sReq && !sAck) plainError("sReq fell before sAck rose");
			if (prevVReq && !vReq && !vAck) plainError("vReq fell before vAck rose");
			// Held fields on the busy port and zeros on the other
			if (sReq || sAck) begin
				comparePort("s", heldFields, sFields);
				comparePort("v", '0, vFields);
			end
			if (vReq || vAck) begin
				comparePort("v", heldFields, vFields);
				comparePort("s", '0, sFields);
			end
			if (finalCheck && !finalDone) begin
				skipIllegal();
				if (dispatchCount != legalCount)
					plainError($sformatf("only %0d of %0d legal words dispatched",
						dispatchCount, legalCount));
				if (ackCount != NUM_WORDS)
					plainError($sformatf("host saw %0d acks for %0d words", ackCount, NUM_WORDS));
				if (illegalCount != count_t'(illegalLines))
					valueError("illegalCount", 32'(illegalLines), 32'(illegalCount));
				$display("%0d words, %0d dispatched, %0d dropped, %0d errors",
					NUM_WORDS, dispatchCount, illegalLines, errors + stimErrors);
				finalDone = 1'b1;
				reportDone <= 1'b1;
			end
			allDispatched <= (dispatchCount == legalCount) && !sReq && !vReq && !sAck && !vAck;
			prevSReq = sReq;
			prevVReq = vReq;
			prevAck  = instrAck;
		end
	end

endmodule

// ==== verif/tbDispatch.sv ====
`timescale 1ns/100ps

module tbDispatch
	import tpuDispatchPkg::*;
();

	localparam int NUM_WORDS   = 24;
	localparam int CYCLE_LIMIT = NUM_WORDS * 40;

	logic        clk;
	logic        rstN;
	logic        instrReq  = 1'b0;
	instrWord_t  instrWord = '0;
	logic        instrAck;
	logic        sReq;
	logic        sAck      = 1'b0;
	opCode_t     sOpCode;
	regIdx_t     sDst;
	regIdx_t     sSrc1;
	regIdx_t     sSrc2;
	imm_t        sImm;
	logic        vReq;
	logic        vAck      = 1'b0;
	opCode_t     vOpCode;
	regIdx_t     vDst;
	regIdx_t     vSrc1;
	regIdx_t     vSrc2;
	imm_t        vImm;
	count_t      illegalCount;

	// Gap, word and unit code per entry
	logic [39:0] stimulus [NUM_WORDS];
	logic [31:0] rngState   = 32'hae8b;
	logic        ackWaiting = 1'b0;
	logic [2:0]  ackDelay   = '0;
	int          cycleCount = 0;
	logic        finalCheck = 1'b0;
	logic        allDispatched;
	logic        reportDone;
	int          failCount;

	tbClock u_clock (.clk, .rstN);

	tpuDispatch u_dut (
		.clk, .rstN,
		.instrReq, .instrWord, .instrAck,
		.sReq, .sAck, .sOpCode, .sDst, .sSrc1, .sSrc2, .sImm,
		.vReq, .vAck, .vOpCode, .vDst, .vSrc1, .vSrc2, .vImm,
		.illegalCount
	);

	dispatchChecker #(.NUM_WORDS(NUM_WORDS)) u_checker (
		.clk, .rstN, .instrAck,
		.sReq, .sAck, .sFields({sOpCode, sDst, sSrc1, sSrc2, sImm}),
		.vReq, .vAck, .vFields({vOpCode, vDst, vSrc1, vSrc2, vImm}),
		.illegalCount, .finalCheck,
		.allDispatched, .reportDone, .failCount
	);

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		logic [31:0] x;
		x = state ^ (state << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ====================
	// Host side
	// ====================

	initial begin
		logic [3:0] gap;
		$readmemh("verif/dispatch_stimulus.txt", stimulus);
		wait (rstN === 1'b1);
		@(posedge clk);
		for (int i = 0; i < NUM_WORDS; i++) begin
			gap = stimulus[i][39:36];
			repeat (gap) @(posedge clk);
			instrWord <= stimulus[i][35:4];
			instrReq  <= 1'b1;
			@(posedge clk);
			while (!instrAck) @(posedge clk);
			instrReq <= 1'b0;
			@(posedge clk);
			while (instrAck) @(posedge clk);
		end
		// Let the queue drain before the last checks
		while (!allDispatched) @(posedge clk);
		finalCheck <= 1'b1;
		while (!reportDone) @(posedge clk);
		if (failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// ====================
	// Execution units
	// ====================

	// Ack after 0 to 7 cycles, drop it once req falls
	always @(posedge clk) begin : unitModel
		logic [2:0] drawn;
		if (!rstN) begin
			sAck       <= 1'b0;
			vAck       <= 1'b0;
			ackWaiting <= 1'b0;
		end else if ((sReq || vReq) && !sAck && !vAck) begin
			if (!ackWaiting) begin
				rngState = nextRandom(rngState);
				drawn    = rngState[2:0];
				if (drawn == 3'd0) begin
					sAck <= sReq;
					vAck <= vReq;
				end else begin
					ackDelay   <= drawn - 1'b1;
					ackWaiting <= 1'b1;
				end
			end else if (ackDelay == 3'd0) begin
				sAck       <= sReq;
				vAck       <= vReq;
				ackWaiting <= 1'b0;
			end else begin
				ackDelay <= ackDelay - 1'b1;
			end
		end else begin
			if (!sReq) sAck <= 1'b0;
			if (!vReq) vAck <= 1'b0;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout: dispatch did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule

// ==== tpuDispatch.f ====
+incdir+source
source/tpuDispatchPkg.sv
source/commandDecoder.sv
source/commandQueue.sv
source/unitDispatch.sv
source/tpuDispatch.sv
verif/tbClock.sv
verif/dispatchChecker.sv
verif/tbDispatch.sv

// ==== Makefile ====
SOURCES := $(wildcard source/*.sv source/*.svh verif/*.sv) tpuDispatch.f

obj_dir/VtbDispatch: $(SOURCES)
	verilator --binary -f tpuDispatch.f --top-module tbDispatch -j 0

run: obj_dir/VtbDispatch verif/dispatch_stimulus.txt
	./obj_dir/VtbDispatch | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== verif/dispatch_stimulus.txt ====
// gap_word_unit: host idle cycles before the word, 32-bit instruction word,
// expected unit 0 scalar, 1 vector, 2 illegal (acked, counted, never dispatched)
2_0422180a_0  // alu scalar
1_28853020_1  // alu vector
3_40e84ffe_0  // mac scalar, imm all ones
0_654b62aa_1  // mac vector
4_8e119154_0  // load/store scalar
1_b3e0fc00_1  // load/store vector, dst 31
2_c0200002_0  // control sub-op 0
5_e843201e_0  // control with vector bit, still scalar
0_d4a00000_2  // control sub-op 5, illegal
1_fc010000_2  // control sub-op 7 with vector bit, illegal
3_cc631806_0  // control sub-op 3, highest legal
2_d0000000_2  // control sub-op 4, illegal
// Back to back words, slow units fill the queue
0_0422180c_0
0_28853022_1
0_40e84ffc_0
0_654b62a8_1
0_b3e0fc02_1
0_fc010002_2  // illegal inside the burst
0_8e119156_0
0_e843201c_0
0_28853024_1
0_cc631808_0
0_654b62ac_1
0_c0200004_0
